/* design/cpu_pkg.sv */
/* shared widths, opcodes and instruction fields for the 16-bit pipeline
   all immediates are sign-extended; the data memory address wraps at 64 words */
package cpu_pkg;

    localparam int word_w      = 16;
    localparam int reg_addr_w  = 3;
    localparam int dmem_words  = 64;
    localparam int dmem_addr_w = $clog2(dmem_words);

    // opcode in instruction bits 15:11
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_halt = 5'd1,
        op_add  = 5'd2,
        op_sub  = 5'd3,
        op_and  = 5'd4,
        op_xor  = 5'd5,
        op_addi = 5'd6,
        op_lbi  = 5'd7,
        op_ld   = 5'd8,
        op_st   = 5'd9,
        op_beqz = 5'd10,
        op_j    = 5'd11
    } opcode_t;

    //////////////////////////////
    // instruction field positions
    //////////////////////////////
    localparam int opcode_hi = 15;
    localparam int opcode_lo = 11;
    localparam int rs_hi     = 10;
    localparam int rs_lo     = 8;
    // r-type second source, also the store data register
    localparam int rt_hi     = 7;
    localparam int rt_lo     = 5;
    localparam int rd_r_hi   = 4;
    localparam int rd_r_lo   = 2;
    // addi and ld destination
    localparam int rd_i_hi   = 7;
    localparam int rd_i_lo   = 5;
    localparam int imm5_hi   = 4;
    localparam int imm8_hi   = 7;
    localparam int imm11_hi  = 10;

    // filler for flushed or empty slots
    localparam logic [word_w-1:0] nop_instr = {op_nop, 11'b0};

endpackage

/* design/decode.sv */
`timescale 1ns/1ns
/* no forwarding: any source matching a write in execute or memory stalls decode
   the register file writes through, so write-back never causes a stall */
module decode
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [word_w-1:0]     if_instr,
    input  logic [word_w-1:0]     if_pc_plus,
    input  logic                  if_valid,
    input  logic                  redirect,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [word_w-1:0]     wb_data,
    input  logic [reg_addr_w-1:0] mem_dest,
    input  logic                  mem_we,
    output logic                  stall,
    output logic                  err,
    output opcode_t               id_op,
    output logic [word_w-1:0]     id_a,
    output logic [word_w-1:0]     id_b,
    output logic [word_w-1:0]     id_imm,
    output logic [word_w-1:0]     id_pc_plus,
    output logic [reg_addr_w-1:0] id_dest,
    output logic                  id_we,
    output logic                  id_valid
);

    logic [word_w-1:0]     rf [2**reg_addr_w];
    opcode_t               op_raw;
    opcode_t               op;
    logic [reg_addr_w-1:0] rs, rt, rd_r, rd_i, dest;
    logic [word_w-1:0]     imm5_ext, imm8_ext, imm11_ext, imm;
    logic [word_w-1:0]     a_data, b_data;
    logic                  use_a, use_b, we, illegal;
    logic                  valid_in, hazard, accept, halted;

    // true if src is still being produced in execute or memory
    function automatic logic raw_hit(input logic [reg_addr_w-1:0] src);
        return (id_we && id_dest == src) || (mem_we && mem_dest == src);
    endfunction

    ///////////////////////////////
    // field extraction
    ///////////////////////////////
    assign op_raw    = opcode_t'(if_instr[opcode_hi:opcode_lo]);
    assign rs        = if_instr[rs_hi:rs_lo];
    assign rt        = if_instr[rt_hi:rt_lo];
    assign rd_r      = if_instr[rd_r_hi:rd_r_lo];
    assign rd_i      = if_instr[rd_i_hi:rd_i_lo];
    assign imm5_ext  = {{(word_w-imm5_hi-1){if_instr[imm5_hi]}}, if_instr[imm5_hi:0]};
    assign imm8_ext  = {{(word_w-imm8_hi-1){if_instr[imm8_hi]}}, if_instr[imm8_hi:0]};
    assign imm11_ext = {{(word_w-imm11_hi-1){if_instr[imm11_hi]}}, if_instr[imm11_hi:0]};

    always_comb begin
        op      = op_raw;
        use_a   = 1'b0;
        use_b   = 1'b0;
        we      = 1'b0;
        dest    = rd_i;
        imm     = '0;
        illegal = 1'b0;
        case (op_raw)
            op_nop, op_halt: begin
                // nothing read or written
            end
            op_add, op_sub, op_and, op_xor: begin
                use_a = 1'b1;
                use_b = 1'b1;
                we    = 1'b1;
                dest  = rd_r;
            end
            op_addi, op_ld: begin
                use_a = 1'b1;
                we    = 1'b1;
                imm   = imm5_ext;
            end
            op_lbi: begin
                we   = 1'b1;
                dest = rs;
                imm  = imm8_ext;
            end
            op_st: begin
                use_a = 1'b1;
                use_b = 1'b1;
                imm   = imm5_ext;
            end
            op_beqz: begin
                use_a = 1'b1;
                imm   = imm8_ext;
            end
            op_j: imm = imm11_ext;
            default: begin
                op      = op_nop;
                illegal = 1'b1;
            end
        endcase
    end

    ///////////////////////////////
    // register file
    ///////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_we) begin
            rf[wb_dest] <= wb_data;
        end
    end

    assign a_data = (wb_we && wb_dest == rs) ? wb_data : rf[rs];
    assign b_data = (wb_we && wb_dest == rt) ? wb_data : rf[rt];

    // hazard and freeze
    assign valid_in = if_valid && !redirect && !halted;
    assign hazard   = (use_a && raw_hit(rs)) || (use_b && raw_hit(rt));
    assign accept   = valid_in && !hazard;
    assign stall    = halted || (valid_in && hazard);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else begin
            if (accept && op == op_halt) halted <= 1'b1;
            if (valid_in && illegal) err <= 1'b1;
        end
    end

    ///////////////////////////////
    // decode to execute register
    ///////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_op    <= op_nop;
            id_we    <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            id_op    <= accept ? op : op_nop;
            id_we    <= accept && we;
            id_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        id_a       <= a_data;
        id_b       <= b_data;
        id_imm     <= imm;
        id_pc_plus <= if_pc_plus;
        id_dest    <= dest;
    end

endmodule

/* design/execute.sv */
`timescale 1ns/1ns
/* branches resolve here; redirect is combinational from the decode register
   and the target is always pc+2 plus the sign-extended immediate */
module execute
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  opcode_t               id_op,
    input  logic [word_w-1:0]     id_a,
    input  logic [word_w-1:0]     id_b,
    input  logic [word_w-1:0]     id_imm,
    input  logic [word_w-1:0]     id_pc_plus,
    input  logic [reg_addr_w-1:0] id_dest,
    input  logic                  id_we,
    input  logic                  id_valid,
    output logic                  redirect,
    output logic [word_w-1:0]     redirect_pc,
    output opcode_t               ex_op,
    output logic [word_w-1:0]     ex_result,
    output logic [word_w-1:0]     ex_store,
    output logic [reg_addr_w-1:0] ex_dest,
    output logic                  ex_we,
    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] mem_dest,
    output logic                  mem_we
);

    logic [word_w-1:0] alu_out;
    logic              a_zero;
    logic              taken;

    ///////////////////////////////
    // alu
    ///////////////////////////////
    always_comb begin
        case (id_op)
            op_add:                alu_out = id_a + id_b;
            op_sub:                alu_out = id_a - id_b;
            op_and:                alu_out = id_a & id_b;
            op_xor:                alu_out = id_a ^ id_b;
            // effective address for ld and st as well
            op_addi, op_ld, op_st: alu_out = id_a + id_imm;
            op_lbi:                alu_out = id_imm;
            default:               alu_out = '0;
        endcase
    end

    ///////////////////////////////
    // branch and jump
    ///////////////////////////////
    assign a_zero      = (id_a == '0);
    assign taken       = (id_op == op_j) || (id_op == op_beqz && a_zero);
    assign redirect    = id_valid && taken;
    assign redirect_pc = id_pc_plus + id_imm;

    // execute to memory register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_op    <= op_nop;
            ex_we    <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            ex_op    <= id_op;
            ex_we    <= id_we;
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_result <= alu_out;
        // rt value, only meaningful for st
        ex_store  <= id_b;
        ex_dest   <= id_dest;
    end

    // hazard view of this register for decode
    assign mem_dest = ex_dest;
    assign mem_we   = ex_we;

endmodule

/* design/fetch.sv */
`timescale 1ns/1ns
/* instruction rom answers one cycle after the address is seen; while stalled
   the address of the held word is presented again so data and pc stay paired */
module fetch
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              redirect,
    input  logic [word_w-1:0] redirect_pc,
    input  logic [word_w-1:0] imem_data,
    output logic [word_w-1:0] imem_addr,
    output logic [word_w-1:0] if_instr,
    output logic [word_w-1:0] if_pc_plus,
    output logic              if_valid
);

    logic [word_w-1:0] pc;
    // pc of the word now on imem_data
    logic [word_w-1:0] rom_pc;
    logic              rom_valid;

    assign imem_addr = (stall && !redirect) ? rom_pc : pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= '0;
            rom_valid <= 1'b0;
        end else if (redirect) begin
            pc        <= redirect_pc;
            // word for the old pc arrives next cycle, drop it
            rom_valid <= 1'b0;
        end else if (!stall) begin
            pc        <= pc + word_w'(2);
            rom_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect || !stall) begin
            rom_pc <= pc;
        end
    end

    ///////////////////////////////
    // instruction register
    ///////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_instr <= nop_instr;
            if_valid <= 1'b0;
        end else if (redirect) begin
            if_instr <= nop_instr;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_instr <= rom_valid ? imem_data : nop_instr;
            if_valid <= rom_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc_plus <= rom_pc + word_w'(2);
        end
    end

endmodule

/* design/memory_access.sv */
`timescale 1ns/1ns
/* 64-word data memory indexed by address bits 6:1, so addresses wrap;
   reads are combinational, stores commit at the clock edge */
module memory_access
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  opcode_t               ex_op,
    input  logic [word_w-1:0]     ex_result,
    input  logic [word_w-1:0]     ex_store,
    input  logic [reg_addr_w-1:0] ex_dest,
    input  logic                  ex_we,
    input  logic                  ex_valid,
    output logic                  st_we,
    output logic [word_w-1:0]     st_addr,
    output logic [word_w-1:0]     st_data,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [word_w-1:0]     wb_data,
    output logic                  halt
);

    logic [word_w-1:0]      dmem [dmem_words];
    logic [dmem_addr_w-1:0] dmem_idx;
    logic [word_w-1:0]      ld_data;

    assign dmem_idx = ex_result[dmem_addr_w:1];
    assign ld_data  = dmem[dmem_idx];

    // store strobe, one cycle per store
    assign st_we   = ex_valid && (ex_op == op_st);
    assign st_addr = ex_result;
    assign st_data = ex_store;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_we) begin
            dmem[dmem_idx] <= ex_store;
        end
    end

    ///////////////////////////////
    // write-back register
    ///////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we <= 1'b0;
            halt  <= 1'b0;
        end else begin
            wb_we <= ex_we;
            // sticky until reset
            if (ex_valid && ex_op == op_halt) halt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= ex_dest;
        wb_data <= (ex_op == op_ld) ? ld_data : ex_result;
    end

endmodule

/* design/proc.sv */
`timescale 1ns/1ns
/* five-stage pipeline without forwarding; imem_data must carry the word for
   imem_addr one cycle after the address is sampled */
module proc
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [word_w-1:0]     imem_data,
    output logic [word_w-1:0]     imem_addr,
    output logic                  reg_we,
    output logic [reg_addr_w-1:0] reg_waddr,
    output logic [word_w-1:0]     reg_wdata,
    output logic                  st_we,
    output logic [word_w-1:0]     st_addr,
    output logic [word_w-1:0]     st_data,
    output logic                  halt,
    output logic                  err
);

    // fetch to decode
    logic [word_w-1:0]     if_instr, if_pc_plus;
    logic                  if_valid, stall;
    // execute back to fetch and decode
    logic                  redirect;
    logic [word_w-1:0]     redirect_pc;
    // decode to execute
    opcode_t               id_op;
    logic [word_w-1:0]     id_a, id_b, id_imm, id_pc_plus;
    logic [reg_addr_w-1:0] id_dest;
    logic                  id_we, id_valid;
    // execute to memory
    opcode_t               ex_op;
    logic [word_w-1:0]     ex_result, ex_store;
    logic [reg_addr_w-1:0] ex_dest, mem_dest;
    logic                  ex_we, ex_valid, mem_we;

    fetch fetch0 (.clk(clk), .arst_n(arst_n), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_data(imem_data), .imem_addr(imem_addr),
        .if_instr(if_instr), .if_pc_plus(if_pc_plus), .if_valid(if_valid));

    decode decode0 (.clk(clk), .arst_n(arst_n), .if_instr(if_instr),
        .if_pc_plus(if_pc_plus), .if_valid(if_valid), .redirect(redirect),
        .wb_we(reg_we), .wb_dest(reg_waddr), .wb_data(reg_wdata),
        .mem_dest(mem_dest), .mem_we(mem_we), .stall(stall), .err(err),
        .id_op(id_op), .id_a(id_a), .id_b(id_b), .id_imm(id_imm),
        .id_pc_plus(id_pc_plus), .id_dest(id_dest), .id_we(id_we), .id_valid(id_valid));

    execute execute0 (.clk(clk), .arst_n(arst_n), .id_op(id_op), .id_a(id_a),
        .id_b(id_b), .id_imm(id_imm), .id_pc_plus(id_pc_plus), .id_dest(id_dest),
        .id_we(id_we), .id_valid(id_valid), .redirect(redirect),
        .redirect_pc(redirect_pc), .ex_op(ex_op), .ex_result(ex_result),
        .ex_store(ex_store), .ex_dest(ex_dest), .ex_we(ex_we), .ex_valid(ex_valid),
        .mem_dest(mem_dest), .mem_we(mem_we));

    // write-back port doubles as the register file write
    memory_access memory0 (.clk(clk), .arst_n(arst_n), .ex_op(ex_op),
        .ex_result(ex_result), .ex_store(ex_store), .ex_dest(ex_dest),
        .ex_we(ex_we), .ex_valid(ex_valid), .st_we(st_we), .st_addr(st_addr),
        .st_data(st_data), .wb_we(reg_we), .wb_dest(reg_waddr),
        .wb_data(reg_wdata), .halt(halt));

endmodule

/* sim.f */
design/cpu_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory_access.sv
design/proc.sv
tb/proc_checker.sv
tb/proc_tb.sv

/* tb/proc_checker.sv */
`timescale 1ns/1ns
/* isa model runs on proc_tb.prog while reset is held; writes and stores are
   matched in order with no cycle numbers, reset values are checked at negedge */
module proc_checker
    import cpu_pkg::*;
(
    input logic                  clk,
    input logic                  arst_n,
    input logic [word_w-1:0]     imem_addr,
    input logic                  reg_we,
    input logic [reg_addr_w-1:0] reg_waddr,
    input logic [word_w-1:0]     reg_wdata,
    input logic                  st_we,
    input logic [word_w-1:0]     st_addr,
    input logic [word_w-1:0]     st_data,
    input logic                  halt,
    input logic                  err
);

    // {dest, data} and {addr, data}
    logic [reg_addr_w+word_w-1:0] exp_reg_q [$];
    logic [2*word_w-1:0]          exp_st_q [$];
    logic [reg_addr_w+word_w-1:0] exp_r;
    logic [2*word_w-1:0]          exp_s;
    logic                         exp_err = 1'b0;
    logic                         halt_seen = 1'b0;
    logic                         err_seen = 1'b0;
    int                           since_reset = 0;
    int                           errors = 0;

    task automatic report_value(input string sig, input logic [word_w-1:0] expected,
                                input logic [word_w-1:0] actual);
        $display("FAIL t=%0t %s expected %h got %h", $time, sig, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    //////////////////////////////
    // isa reference model
    //////////////////////////////
    task automatic build_expected();
        logic [word_w-1:0]     regs [2**reg_addr_w];
        logic [word_w-1:0]     dmem [dmem_words];
        logic [word_w-1:0]     pc, w, a, b, imm5, imm8, imm11, ea, res;
        logic [reg_addr_w-1:0] dest;
        logic                  wr, done;
        int                    steps;
        exp_reg_q.delete();
        exp_st_q.delete();
        exp_err = 1'b0;
        for (int i = 0; i < 2**reg_addr_w; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        // step limit in case a program never reaches halt
        while (!done && steps < 4096) begin
            w     = (pc[word_w-1:1] < 128) ? proc_tb.prog[pc[word_w-1:1]] : {op_halt, 11'b0};
            a     = regs[w[10:8]];
            b     = regs[w[7:5]];
            imm5  = {{11{w[4]}}, w[4:0]};
            imm8  = {{8{w[7]}}, w[7:0]};
            imm11 = {{5{w[10]}}, w[10:0]};
            ea    = a + imm5;
            pc    = pc + 16'd2;
            wr    = 1'b0;
            dest  = w[7:5];
            res   = '0;
            case (w[15:11])
                op_nop: ;
                op_halt: done = 1'b1;
                op_add, op_sub, op_and, op_xor: begin
                    wr   = 1'b1;
                    dest = w[4:2];
                    case (w[15:11])
                        op_add:  res = a + b;
                        op_sub:  res = a - b;
                        op_and:  res = a & b;
                        default: res = a ^ b;
                    endcase
                end
                op_addi: begin
                    wr  = 1'b1;
                    res = ea;
                end
                op_lbi: begin
                    wr   = 1'b1;
                    dest = w[10:8];
                    res  = imm8;
                end
                op_ld: begin
                    wr  = 1'b1;
                    res = dmem[ea[6:1]];
                end
                op_st: begin
                    dmem[ea[6:1]] = b;
                    exp_st_q.push_back({ea, b});
                end
                op_beqz: if (a == '0) pc = pc + imm8;
                op_j: pc = pc + imm11;
                // illegal opcode acts as nop
                default: exp_err = 1'b1;
            endcase
            if (wr) begin
                regs[dest] = res;
                exp_reg_q.push_back({dest, res});
            end
            steps++;
        end
    endtask

    //////////////////////////////
    // event matching
    //////////////////////////////
    always @(posedge clk) begin
        if (!arst_n) begin
            halt_seen = 1'b0;
            err_seen  = 1'b0;
        end else begin
            if (reg_we) begin
                if (halt_seen) begin
                    report_problem("register write after halt");
                end else if (exp_reg_q.size() == 0) begin
                    report_problem("register write that the model does not expect");
                end else begin
                    exp_r = exp_reg_q.pop_front();
                    if (reg_waddr !== exp_r[word_w+:reg_addr_w])
                        report_value("reg_waddr", exp_r[word_w+:reg_addr_w], reg_waddr);
                    if (reg_wdata !== exp_r[word_w-1:0])
                        report_value("reg_wdata", exp_r[word_w-1:0], reg_wdata);
                end
            end
            if (st_we) begin
                if (halt_seen) begin
                    report_problem("store after halt");
                end else if (exp_st_q.size() == 0) begin
                    report_problem("store that the model does not expect");
                end else begin
                    exp_s = exp_st_q.pop_front();
                    if (st_addr !== exp_s[2*word_w-1:word_w])
                        report_value("st_addr", exp_s[2*word_w-1:word_w], st_addr);
                    if (st_data !== exp_s[word_w-1:0])
                        report_value("st_data", exp_s[word_w-1:0], st_data);
                end
            end
            if (halt_seen && halt !== 1'b1)
                report_problem("halt fell before reset");
            if (halt && !halt_seen) begin
                halt_seen = 1'b1;
                if (exp_reg_q.size() != 0)
                    report_problem("halt rose before all expected register writes");
                if (exp_st_q.size() != 0)
                    report_problem("halt rose before all expected stores");
                if (err !== exp_err)
                    report_value("err", exp_err, err);
            end
            if (err_seen && err !== 1'b1)
                report_problem("err fell after it was raised");
            if (err)
                err_seen = 1'b1;
        end
    end

    // outputs quiet during reset and in the first cycle after it
    always @(negedge clk) begin
        if (!arst_n || since_reset == 0) begin
            if (reg_we !== 1'b0) report_value("reg_we", 0, reg_we);
            if (st_we !== 1'b0) report_value("st_we", 0, st_we);
            if (halt !== 1'b0) report_value("halt", 0, halt);
            if (err !== 1'b0) report_value("err", 0, err);
            if (imem_addr !== '0) report_value("imem_addr", 0, imem_addr);
        end
        since_reset = arst_n ? since_reset + 1 : 0;
    end

endmodule

/* tb/proc_tb.sv */
`timescale 1ns/1ns
/* random programs from a fixed xorshift seed; branch offsets are positive and
   even, so every program runs forward into the trailing halt words */
module proc_tb
    import cpu_pkg::*;
();

    localparam int clk_period       = 8;
    localparam int reset_cycles     = 8;
    localparam int post_halt_cycles = 50;
    localparam int prog_words       = 128;
    localparam int body_words       = 100;
    localparam int num_tests        = 6;
    localparam int watchdog_cycles  =
        num_tests * (reset_cycles + post_halt_cycles + 20 * prog_words);
    localparam logic [word_w-1:0] halt_word = {op_halt, 11'b0};

    // program mixes
    localparam int mode_alu    = 0;
    localparam int mode_mem    = 1;
    localparam int mode_branch = 2;

    logic                  clk;
    logic                  arst_n;
    logic [word_w-1:0]     imem_data;
    logic [word_w-1:0]     imem_addr;
    logic                  reg_we, st_we, halt, err;
    logic [reg_addr_w-1:0] reg_waddr;
    logic [word_w-1:0]     reg_wdata, st_addr, st_data;

    logic [word_w-1:0] prog [prog_words];
    logic [31:0]       rng;
    logic [4:0]        ill_op;
    int                passed = 0;
    int                failed = 0;

    proc proc_inst (.clk(clk), .arst_n(arst_n), .imem_data(imem_data),
        .imem_addr(imem_addr), .reg_we(reg_we), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .st_we(st_we), .st_addr(st_addr), .st_data(st_data),
        .halt(halt), .err(err));

    proc_checker chk (.clk(clk), .arst_n(arst_n), .imem_addr(imem_addr),
        .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .st_we(st_we), .st_addr(st_addr), .st_data(st_data), .halt(halt), .err(err));

    always #(clk_period / 2) clk = ~clk;

    // rom with one cycle of latency
    always @(posedge clk) begin
        if (imem_addr[word_w-1:1] < prog_words)
            imem_data <= prog[imem_addr[word_w-1:1]];
        else
            imem_data <= halt_word;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////
    // program generation
    //////////////////////////////
    task automatic make_word(input int mode, output logic [word_w-1:0] w);
        int pick;
        rng = xorshift(rng);
        case (mode)
            mode_alu: pick = rng[31:28] % 6;
            mode_mem: pick = rng[31:28] % 8;
            default:  pick = rng[27] ? 8 + rng[26] : rng[31:28] % 8;
        endcase
        case (pick)
            0: w = {op_add, rng[10:2], 2'b00};
            1: w = {op_sub, rng[10:2], 2'b00};
            2: w = {op_and, rng[10:2], 2'b00};
            3: w = {op_xor, rng[10:2], 2'b00};
            4: w = {op_addi, rng[10:0]};
            // half the constants are zero so beqz is often taken
            5: w = {op_lbi, rng[10:8], rng[25] ? 8'h00 : rng[7:0]};
            6: w = {op_ld, rng[10:0]};
            7: w = {op_st, rng[10:0]};
            8: w = {op_beqz, rng[10:8], 4'h0, rng[3:1], 1'b0};
            default: w = {op_j, 7'h00, rng[3:1], 1'b0};
        endcase
    endtask

    task automatic fill_program(input int mode, input int body);
        logic [word_w-1:0] w;
        for (int i = 0; i < prog_words; i++) begin
            if (i < body) begin
                make_word(mode, w);
                prog[i] = w;
            end else begin
                prog[i] = halt_word;
            end
        end
    endtask

    // reset, run to halt, stay quiet, then hold reset for the next test
    task automatic run_program(input int num, input string name);
        int errors_before;
        errors_before = chk.errors;
        chk.build_expected();
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        while (halt !== 1'b1) @(posedge clk);
        repeat (post_halt_cycles) @(posedge clk);
        if (chk.errors == errors_before) begin
            passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            failed++;
            $display("test %0d %s: fail", num, name);
        end
        arst_n <= 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        imem_data = '0;
        rng       = 32'hcd11_b116;
        fill_program(mode_alu, body_words);
        run_program(1, "alu and lbi dependences");
        fill_program(mode_mem, body_words);
        run_program(2, "loads and stores");
        fill_program(mode_branch, body_words);
        run_program(3, "branches and jumps");
        // halt in the middle of a body full of writes and stores
        fill_program(mode_mem, body_words);
        rng = xorshift(rng);
        prog[20 + rng[5:0]] = halt_word;
        run_program(4, "halt and quiet afterwards");
        fill_program(mode_alu, body_words);
        rng    = xorshift(rng);
        ill_op = 12 + rng[12:8] % 20;
        prog[rng[6:0] % body_words] = {ill_op, rng[10:0]};
        run_program(5, "illegal opcode");
        fill_program(mode_alu, 0);
        run_program(6, "reset values");
        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 num_tests, passed, failed, chk.errors);
        if (failed == 0 && chk.errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: halt was not reached within the allowed cycles");
        $display("Simulation failed");
        $finish;
    end

endmodule
